/* src/coreParamPkg.sv */
`default_nettype none

package coreParamPkg;

    // Register and ROB tag widths
    localparam int PregWidth = 6;
    localparam int RobWidth = 5;    // Without the wrap bit
    localparam int FsqWidth = 4;

    // Issue queue geometry
    localparam int IqDepth = 8;
    localparam int IqIdxWidth = 3;
    localparam int OccWidth = IqIdxWidth + 1;   // Counts 0 to IqDepth

    // Writeback ports that broadcast wakeups
    localparam int WbPorts = 2;

    localparam int PayloadWidth = 16;

endpackage

`default_nettype wire

/* src/issueTypesPkg.sv */
`default_nettype none

package issueTypesPkg;
    import coreParamPkg::*;

    typedef struct packed {
        logic dir;                  // Wrap bit
        logic [RobWidth-1:0] idx;
    } RobIdx;

    typedef struct packed {
        logic [PregWidth-1:0] rs1;
        logic rs1Ready;
        logic [PregWidth-1:0] rs2;
        logic rs2Ready;
        logic [PregWidth-1:0] rd;
        logic rdWe;
        RobIdx robIdx;
    } IssueStatus;

    typedef struct packed {
        logic [FsqWidth-1:0] fsqIdx;
        logic [PayloadWidth-FsqWidth-1:0] offset;
    } BranchRec;

    // One operand word, read as ALU immediate or as branch record
    typedef union packed {
        logic [PayloadWidth-1:0] imm;
        BranchRec branch;
    } IssuePayload;

    typedef struct packed {
        logic en;
        logic we;
        logic [PregWidth-1:0] rd;
    } WakeupBus;

    typedef struct packed {
        logic valid;
        RobIdx robIdx;
    } RedirectInfo;

    typedef struct packed {
        logic [PregWidth-1:0] rs1;
        logic [PregWidth-1:0] rs2;
        logic [PregWidth-1:0] rd;
        logic rdWe;
        RobIdx robIdx;
    } IssueOut;

    typedef struct packed {
        logic [OccWidth-1:0] watermark;
        logic issueHold;
    } IqCfg;

    // True when a is older than b; differing wrap bits reverse the order
    function automatic logic robOlder(input RobIdx a, input RobIdx b);
        return (a.dir == b.dir) ? (a.idx < b.idx) : (a.idx > b.idx);
    endfunction

endpackage

`default_nettype wire

/* src/payloadRam.sv */
`timescale 1ns/1ps
`default_nettype none

module payloadRam
    import coreParamPkg::*, issueTypesPkg::*;
(
    input  logic clk,
    input  logic we_i,
    input  logic [IqIdxWidth-1:0] waddr_i,
    input  IssuePayload wdata_i,
    input  logic [IqIdxWidth-1:0] raddr_i,
    output IssuePayload rdata_o
);

    IssuePayload mem [IqDepth];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i];   // Old data on a same-address write
    end

endmodule

`default_nettype wire

/* src/ageSelector.sv */
`timescale 1ns/1ps
`default_nettype none

module ageSelector
    import coreParamPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [IqDepth-1:0] enqOneHot_i,
    input  logic [IqDepth-1:0] ready_i,
    input  logic grantEn_i,
    output logic [IqDepth-1:0] grant_o
);

    // olderOf[i][j] set means entry j is older than entry i
    logic [IqDepth-1:0] olderOf [IqDepth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < IqDepth; i++) begin
                olderOf[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IqDepth; i++) begin
                if (enqOneHot_i[i]) begin
                    olderOf[i] <= ~enqOneHot_i;     // New entry is the youngest
                end else begin
                    olderOf[i] <= olderOf[i] & ~enqOneHot_i;
                end
            end
        end
    end

    // Oldest ready entry has no ready entry older than itself
    always_comb begin
        for (int i = 0; i < IqDepth; i++) begin
            grant_o[i] = grantEn_i & ready_i[i] & ~(|(olderOf[i] & ready_i));
        end
    end

    grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_o))
        else $error("Age matrix granted more than one entry");

endmodule

`default_nettype wire

/* src/issueCfgRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module issueCfgRegs
    import coreParamPkg::*, issueTypesPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cfgWe_i,
    input  logic cfgAddr_i,
    input  logic [OccWidth-1:0] cfgWdata_i,
    output IqCfg cfg_o
);

    localparam logic AddrWatermark = 1'b0;

    logic [OccWidth-1:0] wmNext;

    // A zero watermark would hold full high forever
    assign wmNext = (cfgWdata_i == '0) ? OccWidth'(1) : cfgWdata_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_o.watermark <= OccWidth'(IqDepth);
            cfg_o.issueHold <= 1'b0;
        end else if (cfgWe_i) begin
            if (cfgAddr_i == AddrWatermark) begin
                cfg_o.watermark <= wmNext;
            end else begin
                cfg_o.issueHold <= cfgWdata_i[0];   // Address 1
            end
        end
    end

endmodule

`default_nettype wire

/* src/issueBank.sv */
`timescale 1ns/1ps
`default_nettype none

module issueBank
    import coreParamPkg::*, issueTypesPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic enq_i,
    input  IssueStatus enqStatus_i,
    input  WakeupBus [WbPorts-1:0] wakeup_i,
    input  RedirectInfo redirect_i,
    input  logic issueReady_i,
    input  IqCfg cfg_i,
    input  logic [IqDepth-1:0] grant_i,
    input  IssuePayload ramRdata_i,
    output logic [IqDepth-1:0] ready_o,
    output logic [IqDepth-1:0] enqOneHot_o,
    output logic grantEn_o,
    output logic [IqIdxWidth-1:0] ramWaddr_o,
    output logic [IqIdxWidth-1:0] ramRaddr_o,
    output logic issueValid_o,
    output IssueOut issue_o,
    output logic [FsqWidth-1:0] issueFsqIdx_o,
    output logic full_o,
    output logic [OccWidth-1:0] occupancy_o
);

    logic [IqDepth-1:0] valid;
    IssueStatus slot [IqDepth];
    IssueStatus enqEntry;

    logic [IqDepth-1:0] wake1, wake2;
    logic [IqDepth-1:0] keep;
    logic [IqDepth-1:0] reserved, busy, free, freeOneHot;
    logic [IqIdxWidth-1:0] grantIdx, heldIdx;
    logic canAccept, took;

    function automatic logic wakeHit(input logic [PregWidth-1:0] tag,
                                     input WakeupBus [WbPorts-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WbPorts; p++) begin
            hit |= bus[p].en & bus[p].we & (bus[p].rd == tag);
        end
        return hit;
    endfunction

    function automatic logic [IqIdxWidth-1:0] toIdx(input logic [IqDepth-1:0] oneHot);
        logic [IqIdxWidth-1:0] idx;
        idx = '0;
        for (int i = 0; i < IqDepth; i++) begin
            if (oneHot[i]) begin
                idx |= IqIdxWidth'(i);
            end
        end
        return idx;
    endfunction

    // Same-cycle wakeup is folded into the new entry
    always_comb begin
        enqEntry = enqStatus_i;
        enqEntry.rs1Ready = enqStatus_i.rs1Ready | wakeHit(enqStatus_i.rs1, wakeup_i);
        enqEntry.rs2Ready = enqStatus_i.rs2Ready | wakeHit(enqStatus_i.rs2, wakeup_i);
    end

    always_comb begin
        for (int i = 0; i < IqDepth; i++) begin
            wake1[i] = wakeHit(slot[i].rs1, wakeup_i);
            wake2[i] = wakeHit(slot[i].rs2, wakeup_i);
            ready_o[i] = valid[i] & slot[i].rs1Ready & slot[i].rs2Ready;
            keep[i] = robOlder(slot[i].robIdx, redirect_i.robIdx);
        end
    end

    // Slot of the held issue output stays out of the free pool so its payload survives
    assign reserved = issueValid_o ? ({{(IqDepth-1){1'b0}}, 1'b1} << heldIdx) : '0;
    assign busy = valid | reserved;
    assign free = ~busy;
    assign freeOneHot = free & (~free + 1'b1);     // Lowest free slot
    assign enqOneHot_o = enq_i ? freeOneHot : '0;
    assign ramWaddr_o = toIdx(freeOneHot);

    assign canAccept = ~issueValid_o | issueReady_i;
    assign grantEn_o = canAccept & ~cfg_i.issueHold & ~redirect_i.valid;
    assign took = |grant_i;
    assign grantIdx = toIdx(grant_i);
    assign ramRaddr_o = canAccept ? grantIdx : heldIdx;   // Re-read while stalled

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (redirect_i.valid) begin
            valid <= valid & keep;      // No enqueue or grant in a redirect cycle
        end else begin
            valid <= (valid | enqOneHot_o) & ~grant_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IqDepth; i++) begin
            if (enqOneHot_o[i]) begin
                slot[i] <= enqEntry;
            end else begin
                if (wake1[i]) begin
                    slot[i].rs1Ready <= 1'b1;
                end
                if (wake2[i]) begin
                    slot[i].rs2Ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issueValid_o <= 1'b0;
        end else if (canAccept) begin
            issueValid_o <= took;
        end
    end

    always_ff @(posedge clk) begin
        if (took) begin
            issue_o.rs1 <= slot[grantIdx].rs1;
            issue_o.rs2 <= slot[grantIdx].rs2;
            issue_o.rd <= slot[grantIdx].rd;
            issue_o.rdWe <= slot[grantIdx].rdWe;
            issue_o.robIdx <= slot[grantIdx].robIdx;
            heldIdx <= grantIdx;
        end
    end

    assign issueFsqIdx_o = ramRdata_i.branch.fsqIdx;

    always_comb begin
        occupancy_o = '0;
        for (int i = 0; i < IqDepth; i++) begin
            occupancy_o += OccWidth'(valid[i]);
        end
    end

    assign full_o = (occupancy_o >= cfg_i.watermark) | (&busy);

    noEnqWhenFull: assert property (@(posedge clk) disable iff (rst) !(enq_i && (&busy)))
        else $error("Enqueue with no free entry");

endmodule

`default_nettype wire

/* src/issueTop.sv */
`timescale 1ns/1ps
`default_nettype none

module issueTop
    import coreParamPkg::*, issueTypesPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic enq_i,
    input  IssueStatus enqStatus_i,
    input  IssuePayload enqPayload_i,
    input  WakeupBus [WbPorts-1:0] wakeup_i,
    input  RedirectInfo redirect_i,
    input  logic issueReady_i,
    input  logic cfgWe_i,
    input  logic cfgAddr_i,
    input  logic [OccWidth-1:0] cfgWdata_i,
    output logic issueValid_o,
    output IssueOut issue_o,
    output IssuePayload issuePayload_o,
    output logic [FsqWidth-1:0] issueFsqIdx_o,
    output logic full_o,
    output logic [OccWidth-1:0] occupancy_o
);

    IqCfg cfg;
    logic [IqDepth-1:0] ready;
    logic [IqDepth-1:0] enqOneHot;
    logic [IqDepth-1:0] grant;
    logic grantEn;
    logic [IqIdxWidth-1:0] ramWaddr, ramRaddr;

    issueCfgRegs cfgRegs (
        .clk(clk),
        .rst(rst),
        .cfgWe_i(cfgWe_i),
        .cfgAddr_i(cfgAddr_i),
        .cfgWdata_i(cfgWdata_i),
        .cfg_o(cfg)
    );

    issueBank bank (
        .clk(clk),
        .rst(rst),
        .enq_i(enq_i),
        .enqStatus_i(enqStatus_i),
        .wakeup_i(wakeup_i),
        .redirect_i(redirect_i),
        .issueReady_i(issueReady_i),
        .cfg_i(cfg),
        .grant_i(grant),
        .ramRdata_i(issuePayload_o),
        .ready_o(ready),
        .enqOneHot_o(enqOneHot),
        .grantEn_o(grantEn),
        .ramWaddr_o(ramWaddr),
        .ramRaddr_o(ramRaddr),
        .issueValid_o(issueValid_o),
        .issue_o(issue_o),
        .issueFsqIdx_o(issueFsqIdx_o),
        .full_o(full_o),
        .occupancy_o(occupancy_o)
    );

    ageSelector selector (
        .clk(clk),
        .rst(rst),
        .enqOneHot_i(enqOneHot),
        .ready_i(ready),
        .grantEn_i(grantEn),
        .grant_o(grant)
    );

    // Read data lines up with the issue register
    payloadRam payload (
        .clk(clk),
        .we_i(enq_i),
        .waddr_i(ramWaddr),
        .wdata_i(enqPayload_i),
        .raddr_i(ramRaddr),
        .rdata_o(issuePayload_o)
    );

endmodule

`default_nettype wire

/* test/issueTb.sv */
`timescale 1ns/1ps
`default_nettype none

module issueTb
    import coreParamPkg::*, issueTypesPkg::*;
();

    localparam int ClkPeriod = 8;
    localparam int IssueWait = 30;
    // Per-test cycle budgets with margin
    localparam int TestBudget = 20 + 60 + 100 + 80 + 60 + 40;

    logic clk, rst, enq, issueReady, cfgWe, cfgAddr;
    logic [OccWidth-1:0] cfgWdata;
    IssueStatus enqStatus;
    IssuePayload enqPayload;
    WakeupBus [WbPorts-1:0] wakeup;
    RedirectInfo redirect;
    logic issueValid, full;
    IssueOut issueOut;
    IssuePayload issuePayload;
    logic [FsqWidth-1:0] issueFsqIdx;
    logic [OccWidth-1:0] occupancy;

    string testName;
    int errorCount;
    logic [RobWidth:0] robCount;

    issueTop uut (
        .clk(clk),
        .rst(rst),
        .enq_i(enq),
        .enqStatus_i(enqStatus),
        .enqPayload_i(enqPayload),
        .wakeup_i(wakeup),
        .redirect_i(redirect),
        .issueReady_i(issueReady),
        .cfgWe_i(cfgWe),
        .cfgAddr_i(cfgAddr),
        .cfgWdata_i(cfgWdata),
        .issueValid_o(issueValid),
        .issue_o(issueOut),
        .issuePayload_o(issuePayload),
        .issueFsqIdx_o(issueFsqIdx),
        .full_o(full),
        .occupancy_o(occupancy)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(TestBudget * ClkPeriod);
        $display("Watchdog: run exceeded %0d cycles without finishing", TestBudget);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog timeout");
    end

    function automatic logic [PregWidth-1:0] randomTag();
        return PregWidth'($urandom);
    endfunction

    function automatic IssuePayload randomPayload();
        IssuePayload p;
        p.imm = PayloadWidth'($urandom);
        return p;
    endfunction

    function automatic RobIdx nextRob();
        RobIdx r;
        r = robCount;
        robCount = robCount + 1'b1;
        return r;
    endfunction

    function automatic IssueStatus makeStatus(input logic rs2Ready,
                                              input logic [PregWidth-1:0] rs2Tag,
                                              input RobIdx rob);
        IssueStatus s;
        s.rs1 = randomTag();
        s.rs1Ready = 1'b1;
        s.rs2 = rs2Tag;
        s.rs2Ready = rs2Ready;
        s.rd = randomTag();
        s.rdWe = 1'($urandom);
        s.robIdx = rob;
        return s;
    endfunction

    // Tags the pipe should see for a dispatched entry
    function automatic IssueOut expectedOut(input IssueStatus s);
        IssueOut o;
        o.rs1 = s.rs1;
        o.rs2 = s.rs2;
        o.rd = s.rd;
        o.rdWe = s.rdWe;
        o.robIdx = s.robIdx;
        return o;
    endfunction

    task automatic check(input string what, input logic [31:0] expVal,
                         input logic [31:0] actVal);
        if (expVal !== actVal) begin
            errorCount++;
            $display("ERR %s %s: expected %h, actual %h", testName, what, expVal, actVal);
            $display("STATUS: FAIL");
            $fatal(1, "Check failed in %s", testName);
        end
    endtask

    task automatic enqueue(input IssueStatus s, input IssuePayload p);
        enq = 1'b1;
        enqStatus = s;
        enqPayload = p;
        @(posedge clk);
        @(negedge clk);
        enq = 1'b0;
    endtask

    task automatic cfgWrite(input logic addr, input logic [OccWidth-1:0] data);
        cfgWe = 1'b1;
        cfgAddr = addr;
        cfgWdata = data;
        @(posedge clk);
        @(negedge clk);
        cfgWe = 1'b0;
    endtask

    task automatic redirectAt(input RobIdx r);
        redirect.valid = 1'b1;
        redirect.robIdx = r;
        @(posedge clk);
        @(negedge clk);
        redirect = '0;
    endtask

    task automatic expectIssue(input IssueStatus s, input IssuePayload p);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!issueValid && waited < IssueWait);
        if (!issueValid) begin
            $display("Test %s: no issue arrived within %0d cycles", testName, IssueWait);
            $display("STATUS: FAIL");
            $fatal(1, "Issue wait timeout");
        end else begin
            check("issue tags", 32'(expectedOut(s)), 32'(issueOut));
            check("payload", 32'(p.imm), 32'(issuePayload.imm));
        end
    endtask

    task automatic expectIdle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("idle issue valid", 32'(0), 32'(issueValid));
        end
    endtask

    task automatic testSingleReady();
        IssueStatus s;
        IssuePayload p;
        testName = "singleReady";
        s = makeStatus(1'b1, randomTag(), nextRob());
        p = randomPayload();
        enqueue(s, p);
        check("valid after one edge", 32'(0), 32'(issueValid));
        @(negedge clk);
        check("valid after two edges", 32'(1), 32'(issueValid));
        check("issue tags", 32'(expectedOut(s)), 32'(issueOut));
        check("payload", 32'(p.imm), 32'(issuePayload.imm));
        expectIdle(2);
    endtask

    task automatic testWakeup();
        IssueStatus s;
        IssuePayload p;
        logic [PregWidth-1:0] tag;
        testName = "wakeup";
        for (int port = 0; port < WbPorts; port++) begin
            tag = randomTag();
            s = makeStatus(1'b0, tag, nextRob());
            p = randomPayload();
            enqueue(s, p);
            repeat (4) begin
                wakeup[0] = '{en: 1'b1, we: 1'b1, rd: tag ^ PregWidth'(1 + $urandom % 63)};
                wakeup[1] = '{en: 1'b1, we: 1'b0, rd: tag};   // Write enable low so no wakeup
                @(negedge clk);
                check("issue while waiting", 32'(0), 32'(issueValid));
            end
            wakeup = '0;
            wakeup[port] = '{en: 1'b1, we: 1'b1, rd: tag};
            @(negedge clk);
            wakeup = '0;
            expectIssue(s, p);
            expectIdle(2);
        end
    endtask

    task automatic testAgeOrder();
        IssueStatus early [5];
        IssueStatus late [5];
        IssuePayload earlyPay [5];
        IssuePayload latePay [5];
        logic [PregWidth-1:0] tag;
        testName = "ageOrder";
        tag = randomTag();
        cfgWrite(1'b1, OccWidth'(1));
        for (int i = 0; i < 5; i++) begin
            early[i] = makeStatus(1'b1, randomTag(), nextRob());
            earlyPay[i] = randomPayload();
            enqueue(early[i], earlyPay[i]);
        end
        // Two blocked entries sit in high slots
        for (int i = 0; i < 2; i++) begin
            late[i] = makeStatus(1'b0, tag, nextRob());
            latePay[i] = randomPayload();
            enqueue(late[i], latePay[i]);
        end
        check("occupancy", 32'(7), 32'(occupancy));
        cfgWrite(1'b1, OccWidth'(0));
        for (int i = 0; i < 5; i++) begin
            expectIssue(early[i], earlyPay[i]);
        end
        cfgWrite(1'b1, OccWidth'(1));
        for (int i = 2; i < 5; i++) begin   // Younger ones take the low slots
            late[i] = makeStatus(1'b1, randomTag(), nextRob());
            latePay[i] = randomPayload();
            enqueue(late[i], latePay[i]);
        end
        wakeup[0] = '{en: 1'b1, we: 1'b1, rd: tag};
        @(negedge clk);
        wakeup = '0;
        cfgWrite(1'b1, OccWidth'(0));
        for (int i = 0; i < 5; i++) begin
            expectIssue(late[i], latePay[i]);
        end
        expectIdle(2);
    endtask

    task automatic testBackPressure();
        IssueStatus s [4];
        IssuePayload p [4];
        testName = "backPressure";
        cfgWrite(1'b0, OccWidth'(3));
        issueReady = 1'b0;
        for (int i = 0; i < 4; i++) begin
            s[i] = makeStatus(1'b1, randomTag(), nextRob());
            p[i] = randomPayload();
        end
        enqueue(s[0], p[0]);
        expectIssue(s[0], p[0]);
        for (int i = 1; i < 4; i++) begin
            enqueue(s[i], p[i]);
            check("occupancy", 32'(i), 32'(occupancy));
            check("full", 32'(i >= 3), 32'(full));
            check("held valid", 32'(1), 32'(issueValid));
            check("held tags", 32'(expectedOut(s[0])), 32'(issueOut));
            check("held payload", 32'(p[0].imm), 32'(issuePayload.imm));
        end
        issueReady = 1'b1;
        for (int i = 1; i < 4; i++) begin
            expectIssue(s[i], p[i]);
        end
        expectIdle(2);
        cfgWrite(1'b0, OccWidth'(IqDepth));
    endtask

    task automatic testRedirect();
        IssueStatus s [5];
        IssuePayload p [5];
        RobIdx flushAt;
        testName = "redirect";
        flushAt = '{dir: 1'b1, idx: RobWidth'(1)};
        cfgWrite(1'b1, OccWidth'(1));
        for (int i = 0; i < 5; i++) begin
            // ROB 30, 31, then wrap to 0, 1, 2 with the dir bit flipped
            s[i] = makeStatus(1'b1, randomTag(), RobIdx'(6'd30 + 6'(i)));
            p[i] = randomPayload();
            enqueue(s[i], p[i]);
        end
        redirectAt(flushAt);
        check("occupancy after flush", 32'(3), 32'(occupancy));
        cfgWrite(1'b1, OccWidth'(0));
        for (int i = 0; i < 3; i++) begin
            expectIssue(s[i], p[i]);
        end
        expectIdle(3);
        check("occupancy at end", 32'(0), 32'(occupancy));
    endtask

    task automatic testBranchPayload();
        IssueStatus s;
        IssuePayload p;
        testName = "branchPayload";
        repeat (3) begin
            s = makeStatus(1'b1, randomTag(), nextRob());
            p.branch.fsqIdx = FsqWidth'($urandom);
            p.branch.offset = (PayloadWidth - FsqWidth)'($urandom);
            enqueue(s, p);
            expectIssue(s, p);
            check("fsq index", 32'(p.branch.fsqIdx), 32'(issueFsqIdx));
        end
        expectIdle(2);
    endtask

    initial begin
        errorCount = 0;
        robCount = '0;
        void'($urandom(32'h2c));
        rst = 1'b1;
        enq = 1'b0;
        enqStatus = '0;
        enqPayload = '0;
        wakeup = '0;
        redirect = '0;
        issueReady = 1'b1;
        cfgWe = 1'b0;
        cfgAddr = 1'b0;
        cfgWdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        testSingleReady();
        testWakeup();
        testAgeOrder();
        testBackPressure();
        testRedirect();
        testBranchPayload();
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/coreParamPkg.sv
src/issueTypesPkg.sv
src/payloadRam.sv
src/ageSelector.sv
src/issueCfgRegs.sv
src/issueBank.sv
src/issueTop.sv
test/issueTb.sv

/* run.sh */
#!/bin/sh
# Build the issue stage testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module issueTb -f list.f -o issueSim \
    && ./obj_dir/issueSim > sim.log 2>&1 \
    || echo "Simulation build or run ended with an error" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
